// ==== sim.f ====
logic/exec_pkg.sv
logic/exec_if.sv
logic/cmp_unit.sv
logic/arith_unit.sv
logic/exec_core.sv
logic/wb_exec_regs.sv
logic/exec_top.sv
sim/exec_tb_asserts.sv
sim/exec_tb.sv

// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= exec_tb
FILELIST    ?= sim.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
FAIL_MSG    ?= test failed
PASS_MSG    ?= test passed
LINT_FLAGS  ?= --lint-only --timing --assert
BUILD_FLAGS ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides, a run that stops early has no pass line either
sim: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED, no pass line in $(LOG)"; exit 1; \
	else \
		echo "simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/exec_tb.sv ====
module exec_tb import exec_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;
    localparam int RESET_CYCLES = 16;
    // operation counts of the test sections
    localparam int N_EDGE     = 5;
    localparam int N_CMP_RAND = 10;
    localparam int N_CZERO    = 16;
    localparam int N_ALU_RAND = 12;
    localparam int N_SHAMT    = 5;
    localparam int N_RUN      = 200;
    localparam int N_OPS = 6 * (N_EDGE * N_EDGE + N_CMP_RAND) + N_CZERO
                         + 8 * N_ALU_RAND + 3 * N_SHAMT + N_RUN;
    // four accesses per operation, plus readback, timing and the two reset reads
    localparam int N_ACCESS       = 4 * N_OPS + 11 + 5 + 2;
    localparam int TIMEOUT_CYCLES = 40 * N_ACCESS;

    logic      clk;
    logic      reset;
    logic      cyc;
    logic      stb;
    logic      we;
    reg_addr_t adr;
    word_t     dat_w;
    word_t     dat_r;
    logic      ack;

    int    seed = 32'h06eb_013c;
    int    cycle = 0;
    int    last_ack_cycle;
    int    last_stb_cycle;
    // expected reads in bus order
    string exp_name_q[$];
    word_t exp_val_q[$];
    bit    exp_op_q[$];
    word_t edge_vals[N_EDGE] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
    int    shamts[N_SHAMT] = '{0, 31, 32, 33, 63};

    exec_top u_exec_top (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // cycle count doubles as the watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            fail_stop($sformatf("timeout after %0d cycles, the bus stopped answering", cycle));
        end
    end

    task automatic fail_stop(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp_val, input word_t act);
        if (act !== exp_val) begin
            fail_stop($sformatf("Mismatch %s: expected %h, actual %h", name, exp_val, act));
        end
    endtask

    task automatic check_op(input string name, input exec_op_t exp_val, input exec_op_t act);
        if (act !== exp_val) begin
            fail_stop($sformatf("Mismatch %s: expected %h, actual %h", name, exp_val, act));
        end
    endtask

    task automatic check_cycles(input string name, input int exp_val, input int act);
        if (act != exp_val) begin
            fail_stop($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp_val, act));
        end
    endtask

    // expected result straight from the operation table
    function automatic word_t exec_ref(input exec_op_t op, input word_t a, input word_t b);
        logic [4:0] sh;
        word_t      r;
        sh = b[4:0];
        case (op)
            4'd0:    r = (a > b) ? a : b;
            4'd1:    r = (a < b) ? a : b;
            4'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4'd3:    r = (a < b) ? 32'd1 : 32'd0;
            4'd4:    r = ($signed(a) > $signed(b)) ? a : b;
            4'd5:    r = ($signed(a) < $signed(b)) ? a : b;
            4'd6:    r = (b == 32'd0) ? 32'd0 : a;
            4'd7:    r = (b != 32'd0) ? 32'd0 : a;
            4'd8:    r = a + b;
            4'd9:    r = a - b;
            4'd10:   r = a & b;
            4'd11:   r = a | b;
            4'd12:   r = a ^ b;
            4'd13:   r = a << sh;
            4'd14:   r = a >> sh;
            // negative a shifts in ones, the complement of a logical shift of ~a
            default: r = a[31] ? ~(~a >> sh) : (a >> sh);
        endcase
        return r;
    endfunction

    task automatic expect_read(input string name, input word_t val, input bit is_op);
        exp_name_q.push_back(name);
        exp_val_q.push_back(val);
        exp_op_q.push_back(is_op);
    endtask

    // starts and returns a drive delay after a posedge
    task automatic bus_access(input logic write, input reg_addr_t addr, input word_t data);
        last_stb_cycle = cycle;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = data;
        // request stays put until ack
        @(negedge clk);
        while (ack !== 1'b1) begin
            @(negedge clk);
        end
        last_ack_cycle = cycle;
        @(posedge clk);
        #DRIVE_DLY;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input reg_addr_t addr, input word_t data);
        bus_access(1'b1, addr, data);
    endtask

    task automatic wb_read(input reg_addr_t addr);
        bus_access(1'b0, addr, '0);
    endtask

    task automatic run_op(input string name, input exec_op_t op, input word_t a, input word_t b);
        wb_write(ADDR_A, a);
        wb_write(ADDR_B, b);
        wb_write(ADDR_OP, word_t'(op));
        expect_read($sformatf("%s op=%h a=%h b=%h", name, op, a, b), exec_ref(op, a, b), 1'b0);
        wb_read(ADDR_RESULT);
    endtask

    task automatic reset_dut();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
    endtask

    // every acked read against the oldest expectation
    always @(negedge clk) begin : compare_reads
        string name;
        word_t exp_val;
        bit    is_op;
        if (!reset && cyc && stb && !we && ack === 1'b1) begin
            if (exp_val_q.size() == 0) begin
                fail_stop($sformatf("read of address %0d acked with nothing expected", adr));
            end else begin
                name    = exp_name_q.pop_front();
                exp_val = exp_val_q.pop_front();
                is_op   = exp_op_q.pop_front();
                if (is_op) begin
                    check_op(name, exec_op_t'(exp_val), exec_op_t'(dat_r));
                    // op register is only 4 bits wide
                    check_word({name, " upper bits"}, '0, dat_r >> OP_W);
                end else begin
                    check_word(name, exp_val, dat_r);
                end
            end
        end
    end

    initial begin : stimulus
        word_t    ra;
        word_t    rb;
        word_t    exp_res;
        exec_op_t rop;
        int       wr_ack;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = ADDR_A;
        dat_w = '0;
        reset_dut();
        expect_read("result after reset", '0, 1'b0);
        wb_read(ADDR_RESULT);

        // op write carries junk above bit 3 during readback
        ra      = $random(seed);
        rb      = $random(seed);
        rop     = exec_op_t'($random(seed));
        exp_res = exec_ref(rop, ra, rb);
        wb_write(ADDR_A, ra);
        wb_write(ADDR_B, rb);
        wb_write(ADDR_OP, {ra[WORD_W-1:OP_W], rop});
        for (int round = 0; round < 2; round++) begin
            expect_read("readback a", ra, 1'b0);
            wb_read(ADDR_A);
            expect_read("readback b", rb, 1'b0);
            wb_read(ADDR_B);
            expect_read("readback op", word_t'(rop), 1'b1);
            wb_read(ADDR_OP);
            if (round == 0) begin
                // result address ignores writes
                wb_write(ADDR_RESULT, ~exp_res);
                expect_read("result write ignored", exp_res, 1'b0);
                wb_read(ADDR_RESULT);
            end
        end

        // compare ops over every edge pairing including equal values
        for (int op = 0; op < 6; op++) begin
            for (int i = 0; i < N_EDGE; i++) begin
                for (int j = 0; j < N_EDGE; j++) begin
                    run_op("cmp edge", exec_op_t'(op), edge_vals[i], edge_vals[j]);
                end
            end
            for (int k = 0; k < N_CMP_RAND; k++) begin
                run_op("cmp random", exec_op_t'(op), $random(seed), $random(seed));
            end
        end

        // czero with zero and nonzero b
        for (int op = 6; op < 8; op++) begin
            for (int k = 0; k < N_CZERO / 2; k++) begin
                case (k % 4)
                    0:       rb = '0;
                    1:       rb = 32'h1;
                    2:       rb = 32'h8000_0000;
                    default: rb = $random(seed) | 1;
                endcase
                run_op("czero", exec_op_t'(op), $random(seed), rb);
            end
        end

        // random b mostly shifts by more than 31
        for (int op = 8; op < 16; op++) begin
            for (int k = 0; k < N_ALU_RAND; k++) begin
                run_op("alu random", exec_op_t'(op), $random(seed), $random(seed));
            end
        end
        // negative a so sra shows the sign fill
        for (int op = 13; op < 16; op++) begin
            for (int k = 0; k < N_SHAMT; k++) begin
                run_op("shift amount", exec_op_t'(op), $random(seed) | 32'h8000_0000,
                       word_t'(shamts[k]));
            end
        end

        // result read straight after the op write is held until done
        ra = $random(seed);
        rb = $random(seed);
        wb_write(ADDR_A, ra);
        wb_write(ADDR_B, rb);
        wb_write(ADDR_OP, 32'h9);
        wr_ack = last_ack_cycle;
        expect_read("result after op write", exec_ref(4'h9, ra, rb), 1'b0);
        wb_read(ADDR_RESULT);
        check_cycles("result ack after op write ack", 2, last_ack_cycle - wr_ack);
        // nothing pending so a plain one cycle ack
        expect_read("result reread", exec_ref(4'h9, ra, rb), 1'b0);
        wb_read(ADDR_RESULT);
        check_cycles("idle result read ack", 1, last_ack_cycle - last_stb_cycle);

        for (int k = 0; k < N_RUN; k++) begin
            rop = exec_op_t'($random(seed));
            run_op("random run", rop, $random(seed), $random(seed));
        end
        reset_dut();
        expect_read("result after second reset", '0, 1'b0);
        wb_read(ADDR_RESULT);

        if (exp_val_q.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            fail_stop($sformatf("%0d expected reads were never acked", exp_val_q.size()));
        end
    end

endmodule

// ==== sim/exec_tb_asserts.sv ====
module exec_tb_asserts (
    input logic clk,
    input logic reset,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic issue,
    input logic done
);

    // one ack per access, never two in a row
    ack_one_cycle: assert property (
        @(posedge clk) disable iff (reset) ack |=> !ack
    ) else $error("ack high in two consecutive cycles");

    // ack only answers a live request
    ack_with_request: assert property (
        @(posedge clk) disable iff (reset) ack |-> (cyc && stb)
    ) else $error("ack without cyc and stb");

    // core answers each issue on the next cycle
    done_after_issue: assert property (
        @(posedge clk) disable iff (reset) issue |=> done
    ) else $error("no done one cycle after issue");

    // done never comes on its own
    done_needs_issue: assert property (
        @(posedge clk) disable iff (reset) done |-> $past(issue)
    ) else $error("done without issue in the previous cycle");

endmodule

// register bank is where the bus and the issue path meet
bind wb_exec_regs exec_tb_asserts u_exec_tb_asserts (
    .clk   (clk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .ack   (ack),
    .issue (port.issue),
    .done  (port.done)
);

// ==== logic/exec_top.sv ====
module exec_top import exec_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // wishbone classic slave
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  reg_addr_t adr,
    input  word_t     dat_w,
    output word_t     dat_r,
    output logic      ack
);

    // issue and result path between bank and core
    exec_if u_exec_if ();

    // bus side, operand registers and result hold-off
    wb_exec_regs u_wb_exec_regs (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .port  (u_exec_if.issuer)
    );

    // compare and alu with the result register
    exec_core u_exec_core (
        .clk   (clk),
        .reset (reset),
        .port  (u_exec_if.executor)
    );

endmodule

// ==== logic/wb_exec_regs.sv ====
module wb_exec_regs import exec_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  reg_addr_t adr,
    input  word_t     dat_w,
    output word_t     dat_r,
    output logic      ack,
    exec_if.issuer    port
);

    wb_state_t state;

    // operand and operation registers
    word_t    a_q;
    word_t    b_q;
    exec_op_t op_q;

    // set by an op write and cleared by done
    logic     pending;
    logic     issue_q;

    // new access seen while idle
    logic     req;
    logic     op_write;
    logic     result_read;
    // result register holds the latest launched operation
    logic     result_ready;

    assign req          = (state == IDLE) && cyc && stb;
    assign op_write     = req && we && (adr == ADDR_OP);
    assign result_read  = !we && (adr == ADDR_RESULT);
    assign result_ready = !pending || port.done;

    // ack is one cycle wide and comes only from the ACK state
    assign ack = state == ACK;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        // result read with an operation still in flight waits
                        if (result_read && !result_ready) begin
                            state <= WAIT_RESULT;
                        end else begin
                            state <= ACK;
                        end
                    end
                end
                ACK: begin
                    state <= IDLE;
                end
                WAIT_RESULT: begin
                    // master gave up the cycle
                    if (!cyc) begin
                        state <= IDLE;
                    end else if (result_ready) begin
                        state <= ACK;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // register writes drop anything sent to the result address
    always_ff @(posedge clk) begin
        if (reset) begin
            a_q  <= '0;
            b_q  <= '0;
            op_q <= '0;
        end else if (req && we) begin
            case (adr)
                ADDR_A:  a_q  <= dat_w;
                ADDR_B:  b_q  <= dat_w;
                ADDR_OP: op_q <= dat_w[OP_W-1:0];
                default: ;
            endcase
        end
    end

    // launch on the op write in the same cycle as its ack
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_q <= 1'b0;
            pending <= 1'b0;
        end else begin
            issue_q <= op_write;
            if (op_write) begin
                pending <= 1'b1;
            end else if (port.done) begin
                pending <= 1'b0;
            end
        end
    end

    // read mux steered by adr which the master holds until ack
    always_comb begin
        case (adr)
            ADDR_A:  dat_r = a_q;
            ADDR_B:  dat_r = b_q;
            ADDR_OP: dat_r = word_t'(op_q);
            default: dat_r = port.result;
        endcase
    end

    assign port.issue = issue_q;
    assign port.op    = op_q;
    assign port.a     = a_q;
    assign port.b     = b_q;

endmodule

// ==== logic/exec_core.sv ====
module exec_core import exec_pkg::*; (
    input logic      clk,
    input logic      reset,
    exec_if.executor port
);

    // unit outputs, both fed with the same operands
    word_t cmp_c;
    word_t alu_c;
    word_t next_result;

    cmp_unit u_cmp_unit (
        .a  (port.a),
        .b  (port.b),
        .op (cmp_op_t'(port.op[SUB_OP_W-1:0])),
        .c  (cmp_c)
    );

    arith_unit u_arith_unit (
        .a  (port.a),
        .b  (port.b),
        .op (alu_op_t'(port.op[SUB_OP_W-1:0])),
        .c  (alu_c)
    );

    // top op bit chooses which unit gets captured
    assign next_result = port.op[UNIT_SEL_BIT] ? alu_c : cmp_c;

    // result lands one cycle after issue, together with done
    always_ff @(posedge clk) begin
        if (reset) begin
            port.result <= '0;
            port.done   <= 1'b0;
        end else begin
            port.done <= port.issue;
            // hold the last result between operations
            if (port.issue) begin
                port.result <= next_result;
            end
        end
    end

endmodule

// ==== logic/arith_unit.sv ====
module arith_unit import exec_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   c
);

    // add and subtract share one adder
    logic                 sub_sel;
    word_t                b_add;
    word_t                sum;
    // only the low bits of b count as shift amount
    logic [SHAMT_W-1:0]   shamt;
    word_t                shl;
    word_t                shr_l;
    word_t                shr_a;

    assign sub_sel = op == ALU_SUB;

    // two's complement subtract as a plus inverted b plus one
    assign b_add = sub_sel ? ~b : b;
    assign sum   = a + b_add + word_t'(sub_sel);

    assign shamt = b[SHAMT_W-1:0];

    // shifter outputs
    assign shl   = a << shamt;
    assign shr_l = a >> shamt;
    // sra replicates the sign bit into the vacated positions
    assign shr_a = word_t'($signed(a) >>> shamt);

    always_comb begin
        case (op)
            ALU_ADD: begin
                c = sum;
            end
            ALU_SUB: begin
                c = sum;
            end
            ALU_AND: begin
                c = a & b;
            end
            ALU_OR: begin
                c = a | b;
            end
            ALU_XOR: begin
                c = a ^ b;
            end
            ALU_SLL: begin
                c = shl;
            end
            ALU_SRL: begin
                c = shr_l;
            end
            ALU_SRA: begin
                c = shr_a;
            end
            default: begin
                c = sum;
            end
        endcase
    end

endmodule

// ==== logic/cmp_unit.sv ====
module cmp_unit import exec_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  cmp_op_t op,
    output word_t   c
);

    // czero codes test b against zero instead of comparing a with b
    logic  czero;
    word_t lhs;
    word_t rhs;
    logic  eq;
    // magnitude compare without the sign bits
    logic  gt_low;
    // a greater than rhs, signed and unsigned
    logic  gt_s;
    logic  gt_u;
    logic  signed_sel;
    logic  gt_sel;
    word_t max_val;
    word_t min_val;

    assign czero = (op == CMP_CZERO_EQZ) || (op == CMP_CZERO_NEZ);
    assign rhs   = czero ? '0 : b;
    assign lhs   = czero ? b : a;
    assign eq    = lhs == rhs;

    assign gt_low = a[WORD_W-2:0] > rhs[WORD_W-2:0];

    // sign bits decide unless they match, then the low bits decide
    always_comb begin
        case ({a[WORD_W-1], rhs[WORD_W-1]})
            2'b01: begin
                // a positive, rhs negative
                gt_s = 1'b1;
                gt_u = 1'b0;
            end
            2'b10: begin
                // a negative, rhs positive
                gt_s = 1'b0;
                gt_u = 1'b1;
            end
            default: begin
                gt_s = gt_low;
                gt_u = gt_low;
            end
        endcase
    end

    // max and min come in signed and unsigned flavours
    assign signed_sel = (op == CMP_MAX) || (op == CMP_MIN);
    assign gt_sel     = signed_sel ? gt_s : gt_u;
    assign max_val    = gt_sel ? a : rhs;
    assign min_val    = gt_sel ? rhs : a;

    always_comb begin
        case (op)
            CMP_MAXU, CMP_MAX: c = max_val;
            CMP_MINU, CMP_MIN: c = min_val;
            // less than is neither greater nor equal
            CMP_SLT:           c = word_t'(!(gt_s || eq));
            CMP_SLTU:          c = word_t'(!(gt_u || eq));
            // zero when b is zero, else a
            CMP_CZERO_EQZ:     c = eq ? '0 : a;
            // zero when b is nonzero, else a
            CMP_CZERO_NEZ:     c = eq ? a : '0;
            default:           c = '0;
        endcase
    end

endmodule

// ==== logic/exec_if.sv ====
// one operation in flight between the register bank and the execute core
interface exec_if import exec_pkg::*; ();

    // single cycle launch strobe
    logic     issue;
    // operation code and operands, stable while issue is high
    exec_op_t op;
    word_t    a;
    word_t    b;

    // registered result, holds until the next done
    word_t    result;
    // single cycle completion strobe, one cycle after issue
    logic     done;

    // register bank side
    modport issuer (
        output issue,
        output op,
        output a,
        output b,
        input  result,
        input  done
    );

    // execute core side
    modport executor (
        input  issue,
        input  op,
        input  a,
        input  b,
        output result,
        output done
    );

endinterface

// ==== logic/exec_pkg.sv ====
package exec_pkg;

    // datapath widths
    localparam int WORD_W   = 32;
    localparam int OP_W     = 4;
    localparam int SUB_OP_W = 3;
    localparam int SHAMT_W  = 5;
    localparam int ADDR_W   = 2;

    // op bit 3 clear picks the compare unit and set picks the alu
    localparam int UNIT_SEL_BIT = 3;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [OP_W-1:0]     exec_op_t;
    typedef logic [SUB_OP_W-1:0] cmp_op_t;
    typedef logic [SUB_OP_W-1:0] alu_op_t;
    typedef logic [ADDR_W-1:0]   reg_addr_t;

    // compare unit sub-codes
    localparam cmp_op_t CMP_MAXU      = 3'b000;
    localparam cmp_op_t CMP_MINU      = 3'b001;
    localparam cmp_op_t CMP_SLT       = 3'b010;
    localparam cmp_op_t CMP_SLTU      = 3'b011;
    localparam cmp_op_t CMP_MAX       = 3'b100;
    localparam cmp_op_t CMP_MIN       = 3'b101;
    localparam cmp_op_t CMP_CZERO_EQZ = 3'b110;
    localparam cmp_op_t CMP_CZERO_NEZ = 3'b111;

    // alu sub-codes
    localparam alu_op_t ALU_ADD = 3'b000;
    localparam alu_op_t ALU_SUB = 3'b001;
    localparam alu_op_t ALU_AND = 3'b010;
    localparam alu_op_t ALU_OR  = 3'b011;
    localparam alu_op_t ALU_XOR = 3'b100;
    localparam alu_op_t ALU_SLL = 3'b101;
    localparam alu_op_t ALU_SRL = 3'b110;
    localparam alu_op_t ALU_SRA = 3'b111;

    // word addresses of the register bank
    localparam reg_addr_t ADDR_A      = 2'd0;
    localparam reg_addr_t ADDR_B      = 2'd1;
    localparam reg_addr_t ADDR_OP     = 2'd2;
    localparam reg_addr_t ADDR_RESULT = 2'd3;

    // bus slave states
    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_RESULT
    } wb_state_t;

endpackage
